// File: sdmacCore.f
logic/sdmacPkg.sv
logic/scsiSm.sv
logic/cpuSm.sv
logic/dmaFifo.sv
logic/sdmacCore.sv
testbench/tb_sdmacCore.sv

// File: run.sh
#!/bin/sh
# Build and run the SDMAC core testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -f sdmacCore.f \
    --top-module tb_sdmacCore -o simv

out=$(./obj_dir/simv)
echo "$out"

echo "$out" | grep -qx "Test completed successfully"

// File: testbench/tb_sdmacCore.sv
/* SDMAC core testbench
   SCSI chip and memory models around the DMA core, register and DMA checks */
`timescale 1ns/1ps

module tb_sdmacCore import sdmacPkg::*; ();

    localparam int TMO = 2000;          // Cycles allowed per wait

    logic  BCLK, CRESET_, dmaDir_i, cpuReq_i, cpuRw_i, scsiDreqN_i, memAck_i;
    byte_t cpuWdata_i, scsiData_i, cpuRdata_o, scsiData_o;
    logic  cpuDone_o, scsiCs_o, scsiRe_o, scsiWe_o, scsiDack_o;
    logic  memReq_o, memWr_o, fifoEmpty_o;
    long_t memWdata_o, memRdata_i;

    byte_t txQ[$];                      // Bytes the chip still has to send
    byte_t gotBytes[$];                 // Bytes the chip received
    byte_t expBytes[$];
    long_t gotLongs[$];                 // Longwords written to memory
    long_t expLongs[$];
    long_t rdLongs[$];                  // Memory contents for reads
    byte_t regByte;                     // Chip register read value
    int    rxWant, rxCount, sentCount, rdIdx, delayLeft;
    bit    holdAck, dackPrev;
    bit    timedOut;                    // A wait ran out of cycles
    int    errors, tests, failedTests;

    sdmacCore dut_i (.*);

    initial begin
        BCLK = 1'b0;
        forever #50 BCLK = ~BCLK;
    end

    // Reference packing, byte 0 lands in the top lane
    function automatic long_t packLong(byte_t b0, byte_t b1, byte_t b2, byte_t b3);
        return {b0, b1, b2, b3};
    endfunction

    // SCSI chip model
    always @(negedge BCLK) begin
        if (dackPrev) begin
            void'(txQ.pop_front());     // Byte was taken at the last edge
            sentCount++;
        end
        if (scsiDack_o && scsiWe_o) begin
            gotBytes.push_back(scsiData_o);
            rxCount++;
        end
        dackPrev = scsiDack_o && scsiRe_o;
        if (scsiCs_o)
            scsiData_i <= regByte;
        else if (txQ.size() > 0)
            scsiData_i <= txQ[0];
        scsiDreqN_i <= dmaDir_i ? (txQ.size() == 0) : (rxCount >= rxWant);
    end

    // Memory model, random latency of 0 to 6 cycles
    always @(negedge BCLK) begin
        memAck_i <= 1'b0;
        if (!memReq_o) begin
            delayLeft = -1;
        end else if (!memAck_i && !holdAck) begin
            if (delayLeft < 0)
                delayLeft = $urandom_range(6, 0);
            if (delayLeft == 0) begin
                memAck_i <= 1'b1;
                if (memWr_o) begin
                    gotLongs.push_back(memWdata_o);
                end else begin
                    memRdata_i <= (rdIdx < rdLongs.size()) ? rdLongs[rdIdx] : '0;
                    rdIdx++;
                end
                delayLeft = -1;
            end else begin
                delayLeft--;
            end
        end
    end

    // Compare process for both data streams
    always @(posedge BCLK) begin
        long_t gl, el;
        byte_t gb, eb;
        if (gotLongs.size() > 0) begin
            gl = gotLongs.pop_front();
            el = (expLongs.size() > 0) ? expLongs.pop_front() : ~gl;
            assert (gl == el) else begin
                $display("CHECK FAILED at %0t: memory write %h, expected %h", $time, gl, el);
                errors++;
            end
        end
        if (gotBytes.size() > 0) begin
            gb = gotBytes.pop_front();
            eb = (expBytes.size() > 0) ? expBytes.pop_front() : ~gb;
            assert (gb == eb) else begin
                $display("CHECK FAILED at %0t: chip byte %h, expected %h", $time, gb, eb);
                errors++;
            end
        end
    end

    task automatic checkVal(input logic ok, input string msg);
        assert (ok) else begin
            $display("CHECK FAILED at %0t: %s", $time, msg);
            errors++;
        end
    endtask

    task automatic giveUp(input string what);
        $display("Timeout while waiting for %s", what);
        timedOut = 1'b1;
        forever @(negedge BCLK);        // Stall here until the watchdog ends the run
    endtask

    task automatic report(input string name, input int errBefore);
        tests++;
        if (errors != errBefore)
            failedTests++;
        $display("%-24s %s", name, (errors == errBefore) ? "passed" : "FAILED");
    endtask

    // One register cycle, returns read byte and cycles to done
    task automatic regAccess(input logic rw, input byte_t wdata,
                             output byte_t rdata, output int cycles);
        int  t;
        bit  strobeSeen;
        strobeSeen = 0;
        cpuReq_i   = 1'b1;
        cpuRw_i    = rw;
        cpuWdata_i = wdata;
        for (t = 0; t < TMO && !(scsiCs_o && (rw ? scsiRe_o : scsiWe_o)); t++)
            @(negedge BCLK);
        if (t >= TMO)
            giveUp("chip select");
        if (!rw)
            checkVal(scsiData_o == wdata, "register write byte on chip bus");
        cycles = t;
        for (t = 0; t < 10 && !cpuDone_o; t++)
            @(negedge BCLK);
        if (!cpuDone_o)
            giveUp("cpuDone_o");
        cycles += t;
        rdata    = cpuRdata_o;
        cpuReq_i = 1'b0;
        @(negedge BCLK);
    endtask

    task automatic waitDrained();
        int t;
        for (t = 0; t < TMO && (expLongs.size() > 0 || !fifoEmpty_o || memReq_o); t++)
            @(negedge BCLK);
        if (t >= TMO)
            giveUp("memory writes");
    endtask

    task automatic queueBytes(input int n);
        byte_t b[4];
        for (int i = 0; i < n / 4; i++) begin
            for (int k = 0; k < 4; k++)
                b[k] = byte_t'($urandom);
            expLongs.push_back(packLong(b[0], b[1], b[2], b[3]));
            for (int k = 0; k < 4; k++)
                txQ.push_back(b[k]);
        end
    endtask

    initial begin
        byte_t rd;
        int    cyc, e, t;
        long_t lw;
        void'($urandom(91600));
        CRESET_ = 1'b0;
        dmaDir_i = DIR_S2F;
        cpuReq_i = 1'b0;
        cpuRw_i = 1'b0;
        cpuWdata_i = '0;
        scsiDreqN_i = 1'b1;
        scsiData_i = '0;
        memRdata_i = '0;
        memAck_i = 1'b0;
        holdAck = 0;
        regByte = 8'h00;
        rxWant = 0;
        rxCount = 0;
        rdIdx = 0;
        delayLeft = -1;
        repeat (4) @(negedge BCLK);
        CRESET_ = 1'b1;

        e = errors;                     // Idle state after reset
        checkVal(!scsiCs_o && !scsiRe_o && !scsiWe_o && !scsiDack_o, "chip strobes idle");
        checkVal(!memReq_o && !cpuDone_o && fifoEmpty_o, "memory side idle and FIFO empty");
        report("reset", e);

        e = errors;
        regAccess(1'b0, 8'h5a, rd, cyc);
        checkVal(cyc <= 4, "cpuDone_o late after write request");
        report("register write", e);

        e = errors;
        regByte = 8'hc3;
        regAccess(1'b1, 8'h00, rd, cyc);
        checkVal(rd == 8'hc3, "register read byte");
        report("register read", e);

        e = errors;                     // 32 bytes into 8 longwords
        queueBytes(32);
        waitDrained();
        report("scsi to memory", e);

        e = errors;                     // FIFO fills while memory stalls
        holdAck = 1;
        sentCount = 0;
        queueBytes(40);
        for (t = 0; t < TMO && sentCount < 32; t++)
            @(negedge BCLK);
        if (t >= TMO)
            giveUp("FIFO to fill");
        repeat (10) @(negedge BCLK);
        checkVal(sentCount == 32, "bytes taken while FIFO full");
        regByte = 8'h96;
        regAccess(1'b1, 8'h00, rd, cyc);
        checkVal(rd == 8'h96, "register read during stalled DMA");
        holdAck = 0;
        waitDrained();
        checkVal(sentCount == 40 && txQ.size() == 0, "all bytes moved once");
        report("back-pressure", e);

        e = errors;                     // Memory to SCSI, last since reads run ahead
        for (int i = 0; i < 8; i++) begin
            lw = $urandom;
            rdLongs.push_back(lw);
            for (int k = 0; k < 4; k++)
                expBytes.push_back(byte_t'(lw >> (24 - 8 * k)));
        end
        rxWant = 32;
        dmaDir_i = ~DIR_S2F;
        for (t = 0; t < TMO && (rxCount < 32 || expBytes.size() > 0); t++)
            @(negedge BCLK);
        if (t >= TMO)
            giveUp("bytes at the chip");
        report("memory to scsi", e);

        $display("Tests run %0d, failed %0d, check errors %0d", tests, failedTests, errors);
        if (errors == 0)
            $display("Test completed successfully");
        else
            $display("Test failed");
        $finish;
    end

    // Watchdog for the whole run and for any stalled wait
    initial begin
        for (int c = 0; c < TMO * 10 && !timedOut; c++)
            @(negedge BCLK);
        if (!timedOut)
            $display("Simulation ran past its overall time limit");
        $display("Test failed");
        $finish;
    end

endmodule

// File: logic/sdmacCore.sv
/* SDMAC DMA core
   SCSI and memory sequencers joined through the longword FIFO */
`timescale 1ns/1ps

module sdmacCore import sdmacPkg::*; (
    input  logic  BCLK,                 // Bus clock
    input  logic  CRESET_,              // Async reset, active low
    input  logic  dmaDir_i,             // 1 = SCSI to memory
    input  logic  cpuReq_i,             // Register access request
    input  logic  cpuRw_i,              // 1 = register read
    input  byte_t cpuWdata_i,           // Register write data
    output byte_t cpuRdata_o,           // Register read data
    output logic  cpuDone_o,            // Register access done
    input  logic  scsiDreqN_i,          // Chip DMA request, active low
    input  byte_t scsiData_i,           // Chip data in
    output logic  scsiCs_o,             // Chip select
    output logic  scsiRe_o,             // Chip read strobe
    output logic  scsiWe_o,             // Chip write strobe
    output logic  scsiDack_o,           // Chip DMA acknowledge
    output byte_t scsiData_o,           // Chip data out
    output logic  memReq_o,             // Memory request
    output logic  memWr_o,              // Memory write
    output long_t memWdata_o,           // Memory write data
    input  long_t memRdata_i,           // Memory read data
    input  logic  memAck_i,             // Memory acknowledge
    output logic  fifoEmpty_o           // FIFO empty
);

    byteCmd_t  byteCmd;                 // SCSI side FIFO commands
    longCmd_t  longCmd;                 // Memory side FIFO commands
    fifoStat_t fifoStat;                // FIFO flags
    byte_t     fifoByte;                // Byte toward the chip
    long_t     fifoLong;                // Longword toward memory
    long_t     fifoWlong;               // Longword from memory

    scsiSm uScsiSm (
        .BCLK        (BCLK),
        .CRESET_     (CRESET_),
        .dmaDir_i    (dmaDir_i),
        .cpuReq_i    (cpuReq_i),
        .cpuRw_i     (cpuRw_i),
        .cpuWdata_i  (cpuWdata_i),
        .scsiDreqN_i (scsiDreqN_i),
        .scsiData_i  (scsiData_i),
        .fifoStat_i  (fifoStat),
        .fifoByte_i  (fifoByte),
        .cpuRdata_o  (cpuRdata_o),
        .cpuDone_o   (cpuDone_o),
        .scsiCs_o    (scsiCs_o),
        .scsiRe_o    (scsiRe_o),
        .scsiWe_o    (scsiWe_o),
        .scsiDack_o  (scsiDack_o),
        .scsiData_o  (scsiData_o),
        .byteCmd_o   (byteCmd)
    );

    cpuSm uCpuSm (
        .BCLK        (BCLK),
        .CRESET_     (CRESET_),
        .dmaDir_i    (dmaDir_i),
        .fifoStat_i  (fifoStat),
        .fifoLong_i  (fifoLong),
        .memRdata_i  (memRdata_i),
        .memAck_i    (memAck_i),
        .memReq_o    (memReq_o),
        .memWr_o     (memWr_o),
        .memWdata_o  (memWdata_o),
        .longCmd_o   (longCmd),
        .fifoWlong_o (fifoWlong)
    );

    dmaFifo uDmaFifo (
        .BCLK        (BCLK),
        .CRESET_     (CRESET_),
        .byteCmd_i   (byteCmd),
        .longCmd_i   (longCmd),
        .scsiData_i  (scsiData_i),      // DMA loads straight from the chip bus
        .fifoWlong_i (fifoWlong),
        .fifoStat_o  (fifoStat),
        .fifoByte_o  (fifoByte),
        .fifoLong_o  (fifoLong),
        .fifoEmpty_o (fifoEmpty_o)
    );

endmodule

// File: logic/dmaFifo.sv
/* DMA FIFO
   Eight longwords, filled or drained a byte at a time on the SCSI side
   and a longword at a time on the memory side */
`timescale 1ns/1ps

module dmaFifo import sdmacPkg::*; (
    input  logic      BCLK,             // Bus clock
    input  logic      CRESET_,          // Async reset, active low
    input  byteCmd_t  byteCmd_i,        // From SCSI sequencer
    input  longCmd_t  longCmd_i,        // From memory sequencer
    input  byte_t     scsiData_i,       // Byte to load
    input  long_t     fifoWlong_i,      // Longword to load
    output fifoStat_t fifoStat_o,       // Flags to both sequencers
    output byte_t     fifoByte_o,       // Byte at next-out/byte pointer
    output long_t     fifoLong_o,       // Longword at next-out
    output logic      fifoEmpty_o       // Empty flag to the outside
);

    localparam int CNT_W = $clog2(FIFO_DEPTH + 1);

    long_t             mem [FIFO_DEPTH]; // Longword storage
    ptr_t              nextIn;           // Entry being filled
    ptr_t              nextOut;          // Entry being drained
    bytePtr_t          bytePtr;          // Lane for the SCSI side
    logic [CNT_W-1:0]  count;            // Complete longwords held
    logic [4:0]        laneLsb;          // Bit offset of the current lane
    logic              push;             // A longword became complete
    logic              pop;              // A longword was consumed

    // Lane 0 is the top byte, 68k order
    assign laneLsb = {~bytePtr, 3'b000};

    assign push = byteCmd_i.incNi || longCmd_i.incNi;
    assign pop  = byteCmd_i.incNo || longCmd_i.incNo;

    assign fifoStat_o.empty = (count == '0);
    assign fifoStat_o.full  = (count == CNT_W'(FIFO_DEPTH));
    assign fifoStat_o.boEq3 = (bytePtr == 2'd3);
    assign fifoEmpty_o      = fifoStat_o.empty;

    assign fifoByte_o = mem[nextOut][laneLsb +: 8];
    assign fifoLong_o = mem[nextOut];

    // Pointers and occupancy
    always_ff @(posedge BCLK or negedge CRESET_) begin
        if (!CRESET_) begin
            nextIn  <= '0;
            nextOut <= '0;
            bytePtr <= '0;
            count   <= '0;
        end else begin
            if (byteCmd_i.incBo) begin
                bytePtr <= bytePtr + 2'd1;  // Wraps after lane 3
            end
            if (push) begin
                nextIn <= (nextIn == ptr_t'(FIFO_DEPTH - 1)) ? '0 : nextIn + 3'd1;
            end
            if (pop) begin
                nextOut <= (nextOut == ptr_t'(FIFO_DEPTH - 1)) ? '0 : nextOut + 3'd1;
            end
            case ({push, pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;    // Both or neither
            endcase
        end
    end

    // Storage, no reset
    always_ff @(posedge BCLK) begin
        if (byteCmd_i.loadByte) begin
            mem[nextIn][laneLsb +: 8] <= scsiData_i;
        end
        if (longCmd_i.wrLong) begin
            mem[nextIn] <= fifoWlong_i;     // Memory read lands whole
        end
    end

    a_noPushFull: assert property (@(posedge BCLK) disable iff (!CRESET_)
        push |-> !fifoStat_o.full);

    a_noPopEmpty: assert property (@(posedge BCLK) disable iff (!CRESET_)
        pop |-> !fifoStat_o.empty);

endmodule

// File: logic/cpuSm.sv
/* Memory side sequencer
   Moves whole longwords between the FIFO and the 32-bit memory bus */
`timescale 1ns/1ps

module cpuSm import sdmacPkg::*; (
    input  logic      BCLK,             // Bus clock
    input  logic      CRESET_,          // Async reset, active low
    input  logic      dmaDir_i,         // Transfer direction level
    input  fifoStat_t fifoStat_i,       // FIFO flags
    input  long_t     fifoLong_i,       // Longword at next-out
    input  long_t     memRdata_i,       // Memory read data
    input  logic      memAck_i,         // Memory cycle end, one cycle
    output logic      memReq_o,         // Memory request, held to ack
    output logic      memWr_o,          // 1 = write to memory
    output long_t     memWdata_o,       // Memory write data
    output longCmd_t  longCmd_o,        // FIFO longword side commands
    output long_t     fifoWlong_o       // Longword to load at next-in
);

    cpuState_t state;                   // Sequencer state
    logic      s2f;                     // Direction is SCSI to memory
    logic      startWr;                 // Begin a memory write
    logic      startRd;                 // Begin a memory read
    logic      ackSeen;                 // Ack for our outstanding cycle

    assign s2f     = (dmaDir_i == DIR_S2F);
    assign startWr = (state == MEM_IDLE) && s2f && !fifoStat_i.empty;  // Drain FIFO
    assign startRd = (state == MEM_IDLE) && !s2f && !fifoStat_i.full;  // Fill FIFO
    assign ackSeen = (state == MEM_WAIT) && memAck_i;

    // FIFO update lands in the ack cycle
    assign longCmd_o.incNo  = ackSeen && memWr_o;   // Written longword leaves
    assign longCmd_o.wrLong = ackSeen && !memWr_o;  // Read data captured
    assign longCmd_o.incNi  = ackSeen && !memWr_o;
    assign fifoWlong_o      = memRdata_i;           // Valid with the ack

    always_ff @(posedge BCLK or negedge CRESET_) begin
        if (!CRESET_) begin
            state    <= MEM_IDLE;
            memReq_o <= 1'b0;
            memWr_o  <= 1'b0;
        end else begin
            case (state)
                MEM_IDLE: begin
                    if (startWr || startRd) begin
                        state    <= MEM_WAIT;
                        memReq_o <= 1'b1;
                        memWr_o  <= startWr;
                    end
                end
                MEM_WAIT: begin
                    if (memAck_i) begin     // Latency set by memory
                        state    <= MEM_DONE;
                        memReq_o <= 1'b0;
                    end
                end
                MEM_DONE: state <= MEM_IDLE; // Flags settled for next decision
                default:  state <= MEM_IDLE;
            endcase
        end
    end

    // Write data taken from next-out when the cycle opens
    always_ff @(posedge BCLK) begin
        if (startWr) begin
            memWdata_o <= fifoLong_i;
        end
    end

    a_reqHold: assert property (@(posedge BCLK) disable iff (!CRESET_)
        memReq_o && !memAck_i |=> memReq_o);

endmodule

// File: logic/scsiSm.sv
/* SCSI side sequencer
   Runs CPU register cycles to the SCSI chip and the byte-wide DMA handshake */
`timescale 1ns/1ps

module scsiSm import sdmacPkg::*; (
    input  logic      BCLK,             // Bus clock
    input  logic      CRESET_,          // Async reset, active low
    input  logic      dmaDir_i,         // Transfer direction level
    input  logic      cpuReq_i,         // Register access request, level
    input  logic      cpuRw_i,          // 1 = read the chip register
    input  byte_t     cpuWdata_i,       // Register write data
    input  logic      scsiDreqN_i,      // Chip DMA request, active low
    input  byte_t     scsiData_i,       // Chip data bus in
    input  fifoStat_t fifoStat_i,       // FIFO flags
    input  byte_t     fifoByte_i,       // FIFO byte at next-out/byte pointer
    output byte_t     cpuRdata_o,       // Register read data
    output logic      cpuDone_o,        // Access complete, one cycle
    output logic      scsiCs_o,         // Chip select
    output logic      scsiRe_o,         // Chip read strobe
    output logic      scsiWe_o,         // Chip write strobe
    output logic      scsiDack_o,       // DMA acknowledge
    output byte_t     scsiData_o,       // Chip data bus out
    output byteCmd_t  byteCmd_o         // FIFO byte side commands
);

    scsiState_t state;                  // Sequencer state
    logic       cpuReqS;                // Synchronized CPU request
    logic       dreqSN;                 // Synchronized chip request, active low
    logic       reqArm;                 // Request seen low since last done
    logic       s2f;                    // Direction is SCSI to memory
    logic       dmaSpace;               // FIFO can take or give a byte
    logic       regStart;               // Register access accepted at IDLE
    byte_t      wdataQ;                 // Held register write byte

    assign s2f      = (dmaDir_i == DIR_S2F);
    assign dmaSpace = s2f ? !fifoStat_i.full : !fifoStat_i.empty;
    assign regStart = (state == IDLE) && cpuReqS && reqArm; // CPU wins over DMA

    // Chip sees the CPU byte only while selected, FIFO byte otherwise
    assign scsiData_o = scsiCs_o ? wdataQ : fifoByte_i;

    // One flop per asynchronous request, idle values in reset
    always_ff @(posedge BCLK or negedge CRESET_) begin
        if (!CRESET_) begin
            cpuReqS <= 1'b0;
            dreqSN  <= 1'b1;
        end else begin
            cpuReqS <= cpuReq_i;
            dreqSN  <= scsiDreqN_i;
        end
    end

    always_ff @(posedge BCLK or negedge CRESET_) begin
        if (!CRESET_) begin
            state      <= IDLE;
            scsiCs_o   <= 1'b0;
            scsiRe_o   <= 1'b0;
            scsiWe_o   <= 1'b0;
            scsiDack_o <= 1'b0;
            cpuDone_o  <= 1'b0;
            reqArm     <= 1'b1;
            byteCmd_o  <= '0;
        end else begin
            cpuDone_o <= 1'b0;          // Pulse defaults
            byteCmd_o <= '0;
            case (state)
                IDLE: begin
                    if (regStart) begin
                        state    <= REG_ACC;
                        scsiCs_o <= 1'b1;
                        scsiRe_o <= cpuRw_i;
                        scsiWe_o <= !cpuRw_i;
                    end else if (!dreqSN && dmaSpace) begin
                        state             <= DMA_ACK;
                        scsiDack_o        <= 1'b1;
                        scsiRe_o          <= s2f;   // Chip drives the bus
                        scsiWe_o          <= !s2f;  // We drive the bus
                        byteCmd_o.loadByte <= s2f;
                        byteCmd_o.incBo   <= 1'b1;
                        byteCmd_o.incNi   <= s2f && fifoStat_i.boEq3;  // Longword filled
                        byteCmd_o.incNo   <= !s2f && fifoStat_i.boEq3; // Longword drained
                    end
                end
                REG_ACC: state <= REG_DONE;  // Strobes held a second cycle
                REG_DONE: begin
                    state     <= IDLE;
                    scsiCs_o  <= 1'b0;
                    scsiRe_o  <= 1'b0;
                    scsiWe_o  <= 1'b0;
                    cpuDone_o <= 1'b1;
                    reqArm    <= 1'b0;      // Ignore the stale request level
                end
                DMA_ACK: begin
                    state      <= DMA_REC1;
                    scsiDack_o <= 1'b0;
                    scsiRe_o   <= 1'b0;
                    scsiWe_o   <= 1'b0;
                end
                DMA_REC1: state <= DMA_REC2;
                DMA_REC2: state <= IDLE;    // dreq now reflects the chip
                default:  state <= IDLE;
            endcase
            if (!cpuReqS) begin
                reqArm <= 1'b1;             // Requester has let go
            end
        end
    end

    // Payload registers
    always_ff @(posedge BCLK) begin
        if (regStart) begin
            wdataQ <= cpuWdata_i;
        end
        if (state == REG_DONE && scsiRe_o) begin
            cpuRdata_o <= scsiData_i;       // Held until next access
        end
    end

    a_reWeExcl: assert property (@(posedge BCLK) disable iff (!CRESET_)
        !(scsiRe_o && scsiWe_o));

    a_dackNoCs: assert property (@(posedge BCLK) disable iff (!CRESET_)
        !(scsiDack_o && scsiCs_o));

endmodule

// File: logic/sdmacPkg.sv
/* SDMAC shared definitions
   Data widths, FIFO geometry and the command/status bundles between blocks */
package sdmacPkg;

    typedef logic [7:0]  byte_t;        // One SCSI data byte
    typedef logic [31:0] long_t;        // One memory longword, byte 0 is the MSB
    typedef logic [2:0]  ptr_t;         // FIFO entry index
    typedef logic [1:0]  bytePtr_t;     // Byte lane within a longword

    localparam int   FIFO_DEPTH = 8;    // Longword entries in the FIFO
    localparam logic DIR_S2F    = 1'b1; // dmaDir level for SCSI to memory

    // Byte side requests from the SCSI sequencer
    typedef struct packed {
        logic loadByte;                 // Write byte at next-in/byte pointer
        logic incBo;                    // Step byte pointer
        logic incNi;                    // Step next-in, longword complete
        logic incNo;                    // Step next-out, longword drained
    } byteCmd_t;

    // Longword side requests from the memory sequencer
    typedef struct packed {
        logic wrLong;                   // Write longword at next-in
        logic incNi;                    // Step next-in
        logic incNo;                    // Step next-out
    } longCmd_t;

    // FIFO flags seen by both sequencers
    typedef struct packed {
        logic empty;                    // No complete longword held
        logic full;                     // All entries hold a longword
        logic boEq3;                    // Byte pointer on the last lane
    } fifoStat_t;

    typedef enum logic [2:0] {
        IDLE,                           // Waiting for CPU or chip request
        REG_ACC,                        // First register access cycle
        REG_DONE,                       // Second cycle, read data sampled
        DMA_ACK,                        // Byte moves with dack
        DMA_REC1,                       // Recovery, dreq settles
        DMA_REC2                        // Recovery, dreq re-sampled
    } scsiState_t;

    typedef enum logic [1:0] {
        MEM_IDLE = 2'd0,                // No memory cycle
        MEM_WAIT = 2'd1,                // Request out, waiting for ack
        MEM_DONE = 2'd2                 // One cycle gap after ack
    } cpuState_t;

endpackage
